//--- Bender.yml
package:
  name: ooo_fetch

sources:
  # design
  - rtl/fetch_pkg.sv
  - rtl/fetch_pc_select.sv
  - rtl/branch_target_buffer.sv
  - rtl/imem_fetch_fsm.sv
  - rtl/fetch_wait_timer.sv
  - rtl/fetch_decode_latch.sv
  - rtl/ooo_fetch_top.sv
  # testbench
  - target: test
    files:
      - dv/imem_model.sv
      - dv/ooo_fetch_tb.sv

//--- all.f
rtl/fetch_pkg.sv
rtl/fetch_pc_select.sv
rtl/branch_target_buffer.sv
rtl/imem_fetch_fsm.sv
rtl/fetch_wait_timer.sv
rtl/fetch_decode_latch.sv
rtl/ooo_fetch_top.sv
dv/imem_model.sv
dv/ooo_fetch_tb.sv

//--- dv/imem_model.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction memory model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module imem_model import fetch_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  word_t addr,
  input  logic  ren,
  output logic  busy,
  output word_t rdata
);

  timeunit 1ns;
  timeprecision 1ps;

  // word content is address xor this pattern
  localparam word_t MEM_PATTERN = 32'h5a3c96e1;
  // this address is never answered
  localparam word_t DEAD_ADDR = 32'h80000400;

  int seed = 24144;
  // wait cycles left before the current transfer completes
  logic [1:0] wait_left;
  word_t word;

  assign word = addr ^ MEM_PATTERN;

  // stored little endian, the fetch latch swaps it back
  assign rdata = {word[7:0], word[15:8], word[23:16], word[31:24]};

  assign busy = ren && ((wait_left != 2'd0) || (addr == DEAD_ADDR));

  always @(posedge CLK or negedge nRST) begin
    if (!nRST) begin
      wait_left <= 2'd0;
    end else if (ren && !busy) begin
      // transfer done, pick 0..3 waits for the next one
      wait_left <= 2'($random(seed) & 3);
    end else if (ren && (wait_left != 2'd0)) begin
      wait_left <= wait_left - 2'd1;
    end
  end

endmodule

//--- dv/ooo_fetch_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction fetch testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module ooo_fetch_tb import fetch_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_NS = 20;
  // same pattern as the memory model
  localparam word_t MEM_PATTERN = 32'h5a3c96e1;
  localparam word_t DEAD_ADDR = 32'h80000400;
  // trained branch and its target
  localparam word_t BP_PC = 32'h80000500;
  localparam word_t BP_TARGET = 32'h80000600;
  // upper bound on tokens the tests ask for
  localparam int PLANNED_FETCHES = 120;
  localparam int WATCHDOG_NS = PLANNED_FETCHES * (3 + BUS_TIMEOUT_CYCLES + 4) * CLK_NS;

  logic CLK, nRST, halt, stall, if_id_flush, npc_sel, insert_priv_pc;
  logic br_update, br_update_taken, busy, ren, token, prediction, mal_insn, fault_insn;
  word_t brj_addr, priv_pc, br_update_pc, br_update_target, rdata, addr;
  word_t pc, pc4, instr;

  int seed = 24144;
  int value_errs = 0;
  int other_errs = 0;
  // reference model state, updated on the falling edge
  int tok_cnt = 0;
  int fault_waits = 0;
  int chk_waits = 0;
  word_t exp_next = RESET_PC;
  word_t chk_pc = '0;
  word_t chk_instr = '0;
  logic chk_new = 1'b0;
  logic chk_pred = 1'b0;
  logic chk_mal = 1'b0;
  logic chk_fault = 1'b0;
  logic prev_token = 1'b0;
  logic prev_stall = 1'b0;
  logic bp_on = 1'b0;
  logic seen_ren = 1'b0;
  logic past_first_edge = 1'b0;

  ooo_fetch_top dut_i (
    .CLK, .nRST, .halt, .stall, .if_id_flush, .npc_sel, .brj_addr, .insert_priv_pc,
    .priv_pc, .br_update, .br_update_pc, .br_update_target, .br_update_taken, .busy,
    .rdata, .addr, .ren, .token, .pc, .pc4, .instr, .prediction, .mal_insn, .fault_insn
  );

  imem_model mem_i (.CLK, .nRST, .addr, .ren, .busy, .rdata);

  initial begin
    CLK = 1'b0;
    forever #(CLK_NS / 2) CLK = ~CLK;
  end

  always @(posedge CLK) begin
    past_first_edge <= 1'b1;
    if (ren) begin
      seen_ren <= 1'b1;
    end
  end

  // expected stream where a token held under stall is not new
  always @(negedge CLK) begin
    chk_new = nRST && token && !(prev_token && prev_stall);
    if (chk_new) begin
      chk_pc = exp_next;
      chk_mal = (exp_next[1:0] != 2'b00);
      chk_fault = (exp_next == DEAD_ADDR);
      chk_instr = (chk_mal || chk_fault) ? NOP_INSTR : (exp_next ^ MEM_PATTERN);
      chk_pred = bp_on && (exp_next == BP_PC);
      chk_waits = fault_waits;
      fault_waits = 0;
      exp_next = chk_pred ? BP_TARGET : exp_next + 32'd4;
      tok_cnt++;
    end
    if (ren && busy && (addr == DEAD_ADDR)) begin
      fault_waits++;
    end
    // privileged pc beats branch redirect
    if (insert_priv_pc) begin
      exp_next = priv_pc;
    end else if (npc_sel) begin
      exp_next = brj_addr;
    end
    prev_token = token;
    prev_stall = stall;
  end

  task automatic report_mismatch(input string name, input word_t expv, input word_t got);
    value_errs++;
    $display("ERROR %s expected %h got %h", name, expv, got);
  endtask

  reset_quiet: assert property (@(posedge CLK)
    (past_first_edge && !nRST) || $rose(nRST) |-> !ren && !token && !mal_insn && !fault_insn)
    else begin
      value_errs++;
      $display("ERROR reset outputs expected 0 got ren=%h token=%h mal_insn=%h fault_insn=%h",
               $sampled(ren), $sampled(token), $sampled(mal_insn), $sampled(fault_insn));
    end
  first_addr: assert property (@(posedge CLK) disable iff (!nRST)
    ren && !seen_ren |-> addr == RESET_PC)
    else report_mismatch("addr", RESET_PC, $sampled(addr));
  tok_pc: assert property (@(posedge CLK) disable iff (!nRST) chk_new |-> pc == chk_pc)
    else report_mismatch("pc", chk_pc, $sampled(pc));
  tok_pc4: assert property (@(posedge CLK) disable iff (!nRST)
    chk_new |-> pc4 == chk_pc + 32'd4)
    else report_mismatch("pc4", chk_pc + 32'd4, $sampled(pc4));
  tok_instr: assert property (@(posedge CLK) disable iff (!nRST) chk_new |-> instr == chk_instr)
    else report_mismatch("instr", chk_instr, $sampled(instr));
  tok_pred: assert property (@(posedge CLK) disable iff (!nRST)
    chk_new |-> prediction == chk_pred)
    else report_mismatch("prediction", word_t'(chk_pred), word_t'($sampled(prediction)));
  tok_mal: assert property (@(posedge CLK) disable iff (!nRST) chk_new |-> mal_insn == chk_mal)
    else report_mismatch("mal_insn", word_t'(chk_mal), word_t'($sampled(mal_insn)));
  tok_fault: assert property (@(posedge CLK) disable iff (!nRST)
    chk_new |-> fault_insn == chk_fault)
    else report_mismatch("fault_insn", word_t'(chk_fault), word_t'($sampled(fault_insn)));
  fault_delay: assert property (@(posedge CLK) disable iff (!nRST)
    chk_new && chk_fault |-> chk_waits == BUS_TIMEOUT_CYCLES)
    else report_mismatch("wait cycles", BUS_TIMEOUT_CYCLES, chk_waits);
  stall_hold: assert property (@(posedge CLK) disable iff (!nRST)
    token && stall && !if_id_flush && !npc_sel && !insert_priv_pc
      |=> token && $stable(pc) && $stable(instr))
    else begin
      other_errs++;
      $display("decode fields changed while stall was high");
    end
  flush_clear: assert property (@(posedge CLK) disable iff (!nRST) if_id_flush |=> !token)
    else report_mismatch("token", '0, word_t'($sampled(token)));
  no_mal_ren: assert property (@(posedge CLK) disable iff (!nRST) ren |-> addr[1:0] == 2'b00)
    else begin
      other_errs++;
      $display("bus read issued on misaligned address %h", $sampled(addr));
    end

  task automatic next_cycle();
    @(posedge CLK);
    #2;
  endtask

  task automatic wait_tokens(input int n);
    int target;
    target = tok_cnt + n;
    do begin
      @(posedge CLK);
    end while (tok_cnt < target);
    #2;
  endtask

  // one-cycle hazard strobes
  task automatic strobe_redirect(input logic flush, input logic use_priv, input logic use_br,
                                 input word_t p_addr, input word_t b_addr);
    if_id_flush = flush;
    insert_priv_pc = use_priv;
    priv_pc = p_addr;
    npc_sel = use_br;
    brj_addr = b_addr;
    next_cycle();
    if_id_flush = 1'b0;
    insert_priv_pc = 1'b0;
    npc_sel = 1'b0;
  endtask

  task automatic train_branch(input word_t b_pc, input word_t b_target, input logic taken);
    br_update = 1'b1;
    br_update_pc = b_pc;
    br_update_target = b_target;
    br_update_taken = taken;
    next_cycle();
    br_update = 1'b0;
  endtask

  initial begin
    int gap;
    nRST = 1'b0;
    halt = 1'b0;
    stall = 1'b0;
    if_id_flush = 1'b0;
    npc_sel = 1'b0;
    brj_addr = '0;
    insert_priv_pc = 1'b0;
    priv_pc = '0;
    br_update = 1'b0;
    br_update_pc = '0;
    br_update_target = '0;
    br_update_taken = 1'b0;
    repeat (5) @(posedge CLK);
    #2 nRST = 1'b1;
    // straight line from the boot address
    wait_tokens(20);
    // random back-pressure, then one long stall
    repeat (40) begin
      stall = 1'($random(seed) & 1);
      next_cycle();
    end
    stall = 1'b1;
    repeat (6) next_cycle();
    stall = 1'b0;
    wait_tokens(4);
    strobe_redirect(1'b0, 1'b0, 1'b1, '0, 32'h80000040);
    wait_tokens(5);
    // both strobes at once
    strobe_redirect(1'b0, 1'b1, 1'b1, 32'h80000080, 32'h800000c0);
    wait_tokens(5);
    // redirects landing in wait states and under stall
    for (int i = 0; i < 6; i++) begin
      gap = $random(seed) & 3;
      repeat (gap) begin
        stall = 1'($random(seed) & 1);
        next_cycle();
      end
      strobe_redirect(1'b0, 1'b0, 1'b1, '0, word_t'(32'h80000100 + i * 32'h40));
    end
    stall = 1'b0;
    wait_tokens(4);
    strobe_redirect(1'b1, 1'b0, 1'b1, '0, 32'h80000280);
    wait_tokens(4);
    // flush alone on a token that a stalled decode would otherwise hold
    while (!token) begin
      next_cycle();
    end
    stall = 1'b1;
    strobe_redirect(1'b1, 1'b0, 1'b0, '0, '0);
    stall = 1'b0;
    wait_tokens(2);
    // train far from the branch, then run through it
    strobe_redirect(1'b0, 1'b0, 1'b1, '0, 32'h80000800);
    train_branch(BP_PC, BP_TARGET, 1'b1);
    train_branch(BP_PC, BP_TARGET, 1'b1);
    bp_on = 1'b1;
    strobe_redirect(1'b0, 1'b0, 1'b1, '0, BP_PC - 32'd8);
    wait_tokens(6);
    train_branch(BP_PC, BP_TARGET, 1'b0);
    train_branch(BP_PC, BP_TARGET, 1'b0);
    bp_on = 1'b0;
    strobe_redirect(1'b0, 1'b0, 1'b1, '0, BP_PC - 32'd8);
    wait_tokens(5);
    // misaligned target, then the dead address
    strobe_redirect(1'b0, 1'b0, 1'b1, '0, 32'h80000302);
    wait_tokens(2);
    strobe_redirect(1'b0, 1'b0, 1'b1, '0, DEAD_ADDR);
    wait_tokens(3);
    repeat (4) next_cycle();
    $display("errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs + other_errs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // hang guard
  initial begin
    #(WATCHDOG_NS);
    other_errs++;
    $display("run hung, watchdog expired before the tests finished");
    $display("errors: %0d value, %0d other", value_errs, other_errs);
    $display("Done: errors found");
    $finish;
  end

endmodule

//--- rtl/branch_target_buffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// direct-mapped branch target buffer
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module branch_target_buffer import fetch_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  word_t cur_pc,
  input  logic  br_update,
  input  word_t br_update_pc,
  input  word_t br_update_target,
  input  logic  br_update_taken,
  output logic  predict_taken,
  output word_t target_addr
);

  logic [BTB_ENTRIES-1:0] valid;
  logic [BTB_TAG_BITS-1:0] tag [BTB_ENTRIES];
  word_t target [BTB_ENTRIES];
  logic [1:0] ctr [BTB_ENTRIES];

  logic [BTB_IDX_BITS-1:0] rd_idx;
  logic [BTB_TAG_BITS-1:0] rd_tag;
  logic rd_hit;
  logic [BTB_IDX_BITS-1:0] up_idx;
  logic [BTB_TAG_BITS-1:0] up_tag;
  logic up_hit;

  // word aligned, so index starts at bit 2
  assign rd_idx = cur_pc[BTB_IDX_BITS+1:2];
  assign rd_tag = cur_pc[31:BTB_IDX_BITS+2];
  assign up_idx = br_update_pc[BTB_IDX_BITS+1:2];
  assign up_tag = br_update_pc[31:BTB_IDX_BITS+2];

  // lookup side
  assign rd_hit = valid[rd_idx] && (tag[rd_idx] == rd_tag);
  // msb of the counter means taken
  assign predict_taken = rd_hit && ctr[rd_idx][1];
  assign target_addr = target[rd_idx];

  // training side
  assign up_hit = valid[up_idx] && (tag[up_idx] == up_tag);

  // valid bits, only taken misses allocate
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else if (br_update && br_update_taken && !up_hit) begin
      valid[up_idx] <= 1'b1;
    end
  end

  // entry payload
  always_ff @(posedge CLK) begin
    if (br_update) begin
      if (up_hit) begin
        if (br_update_taken) begin
          // saturate at strongly taken
          if (ctr[up_idx] != 2'b11) begin
            ctr[up_idx] <= ctr[up_idx] + 2'd1;
          end
          // indirect jumps may land elsewhere this time
          target[up_idx] <= br_update_target;
        end else if (ctr[up_idx] != 2'b00) begin
          ctr[up_idx] <= ctr[up_idx] - 2'd1;
        end
      end else if (br_update_taken) begin
        // new entry, weakly taken
        tag[up_idx] <= up_tag;
        target[up_idx] <= br_update_target;
        ctr[up_idx] <= BTB_CTR_ALLOC;
      end
    end
  end

endmodule

//--- rtl/fetch_decode_latch.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch to decode pipeline register
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fetch_decode_latch import fetch_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  halt,
  input  logic  stall,
  input  logic  if_id_flush,
  input  logic  redirect,
  input  logic  fetch_done,
  input  word_t cur_pc,
  input  word_t cur_pc4,
  input  word_t fetch_word,
  input  logic  predict_taken,
  input  logic  mal_addr,
  input  logic  fetch_fault,
  output logic  token,
  output word_t pc,
  output word_t pc4,
  output word_t instr,
  output logic  prediction,
  output logic  mal_insn,
  output logic  fault_insn
);

  word_t bus_instr;
  logic kill;
  logic load;

  // byte order of the bus word
  assign bus_instr = BUS_LITTLE_ENDIAN ?
    {fetch_word[7:0], fetch_word[15:8], fetch_word[23:16], fetch_word[31:24]} : fetch_word;

  assign kill = if_id_flush || redirect;
  assign load = !halt && !kill && !stall && fetch_done;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      token <= 1'b0;
      pc <= '0;
      pc4 <= '0;
      prediction <= 1'b0;
      mal_insn <= 1'b0;
      fault_insn <= 1'b0;
    end else if (halt) begin
      token <= 1'b0;
      pc <= '0;
      pc4 <= '0;
      mal_insn <= 1'b0;
      fault_insn <= 1'b0;
    end else if (kill) begin
      // squash whatever decode is holding
      token <= 1'b0;
      mal_insn <= 1'b0;
      fault_insn <= 1'b0;
    end else if (load) begin
      token <= 1'b1;
      pc <= cur_pc;
      pc4 <= cur_pc4;
      prediction <= predict_taken;
      mal_insn <= mal_addr;
      fault_insn <= fetch_fault;
    end else if (!stall) begin
      // bubble while the bus is still busy
      token <= 1'b0;
    end
  end

  // instruction payload, bad fetches become a nop
  always_ff @(posedge CLK) begin
    if (load) begin
      instr <= (mal_addr || fetch_fault) ? NOP_INSTR : bus_instr;
    end
  end

endmodule

//--- rtl/fetch_pc_select.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// program counter and next-pc select
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fetch_pc_select import fetch_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  halt,
  input  logic  stall,
  input  logic  fetch_done,
  input  logic  insert_priv_pc,
  input  word_t priv_pc,
  input  logic  npc_sel,
  input  word_t brj_addr,
  input  logic  predict_taken,
  input  word_t target_addr,
  output word_t cur_pc,
  output word_t cur_pc4,
  output logic  redirect
);

  word_t pc_q;
  word_t next_pc;

  // sequential successor, shared with the decode latch
  assign cur_pc4 = pc_q + 32'd4;
  assign cur_pc = pc_q;

  // either hazard strobe moves fetch off the current stream
  assign redirect = insert_priv_pc | npc_sel;

  // priority: privileged pc, then resolved branch/jump,
  // then btb prediction, then fall through
  always_comb begin
    if (insert_priv_pc) begin
      next_pc = priv_pc;
    end else if (npc_sel) begin
      next_pc = brj_addr;
    end else if (predict_taken) begin
      next_pc = target_addr;
    end else begin
      next_pc = cur_pc4;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc_q <= RESET_PC;
    end else if (halt) begin
      // parked at the boot address until halt drops
      pc_q <= RESET_PC;
    end else if (redirect) begin
      // redirects take effect even under stall
      pc_q <= next_pc;
    end else if (fetch_done && !stall) begin
      pc_q <= next_pc;
    end
  end

endmodule

//--- rtl/fetch_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction fetch shared definitions
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package fetch_pkg;

  // generic rv32 word for pc, bus address and instruction
  typedef logic [31:0] word_t;

  // first fetch address, also where halt parks the pc
  localparam word_t RESET_PC = 32'h80000000;

  // branch target buffer geometry
  // index from pc[4:2], tag from the remaining upper bits
  localparam int unsigned BTB_ENTRIES = 8;
  localparam int unsigned BTB_IDX_BITS = 3;
  localparam int unsigned BTB_TAG_BITS = 27;

  // counter value written on allocation (weakly taken)
  localparam logic [1:0] BTB_CTR_ALLOC = 2'b10;

  // bus wait cycles before the fetch is given up as faulted
  localparam int unsigned BUS_TIMEOUT_CYCLES = 16;

  // wait counter must be able to hold BUS_TIMEOUT_CYCLES itself
  localparam int unsigned TIMER_BITS = $clog2(BUS_TIMEOUT_CYCLES + 1);

  // memory returns little-endian words, decode wants them swapped
  localparam bit BUS_LITTLE_ENDIAN = 1'b1;

  // addi x0, x0, 0
  // handed to decode in place of a faulted or misaligned fetch
  localparam word_t NOP_INSTR = 32'h00000013;

  // bus request sequencing
  //   IDLE     one quiet cycle, no ren
  //   REQUEST  ren up on cur_pc
  //   HOLD     word captured while decode is stalled
  //   DISCARD  draining a transfer made stale by a redirect
  //   HALTED   core halted, bus idle
  typedef enum logic [2:0] {
    IDLE,
    REQUEST,
    HOLD,
    DISCARD,
    HALTED
  } fetch_state_t;

endpackage

//--- rtl/fetch_wait_timer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bus wait timeout counter
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module fetch_wait_timer import fetch_pkg::*; (
  input  logic CLK,
  input  logic nRST,
  input  logic wait_active,
  output logic timeout
);

  localparam logic [TIMER_BITS-1:0] CNT_MAX = TIMER_BITS'(BUS_TIMEOUT_CYCLES);
  localparam logic [TIMER_BITS-1:0] CNT_LAST = TIMER_BITS'(BUS_TIMEOUT_CYCLES - 1);

  // wait cycles seen so far on the current transfer
  logic [TIMER_BITS-1:0] wait_cnt;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wait_cnt <= '0;
    end else if (!wait_active) begin
      // any answer or idle cycle restarts the count
      wait_cnt <= '0;
    end else if (wait_cnt != CNT_MAX) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // fires in the last allowed wait cycle
  // counter saturates past it, so only one pulse per transfer
  assign timeout = wait_active && (wait_cnt == CNT_LAST);

endmodule

//--- rtl/imem_fetch_fsm.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction bus request FSM
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module imem_fetch_fsm import fetch_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  halt,
  input  logic  stall,
  input  logic  redirect,
  input  word_t cur_pc,
  input  logic  busy,
  input  word_t rdata,
  input  logic  timeout,
  output word_t addr,
  output logic  ren,
  output logic  fetch_done,
  output word_t fetch_word,
  output logic  fetch_fault,
  output logic  mal_addr,
  output logic  wait_active
);

  fetch_state_t state, next_state;
  logic misaligned;
  // one cycle spent on a misaligned pc before reporting it
  logic mal_seen;
  logic hold_load;
  logic held_fault;
  word_t held_word;
  // address of the stale transfer still on the bus
  word_t discard_addr;

  assign misaligned = (cur_pc[1:0] != 2'b00);
  assign mal_addr = misaligned;

  // no bus request for a misaligned pc
  assign ren = ((state == REQUEST) && !misaligned) || (state == DISCARD);
  assign addr = (state == DISCARD) ? discard_addr : cur_pc;
  assign wait_active = ren && busy;
  assign fetch_word = (state == HOLD) ? held_word : rdata;

  always_comb begin
    next_state = state;
    fetch_done = 1'b0;
    fetch_fault = 1'b0;
    hold_load = 1'b0;
    case (state)
      IDLE: next_state = REQUEST;
      REQUEST: begin
        if (redirect) begin
          // a word arriving now is simply dropped
          if (timeout) begin
            // timed out transfer is abandoned rather than drained
            next_state = IDLE;
          end else if (ren && busy) begin
            next_state = DISCARD;
          end
        end else if (misaligned) begin
          fetch_done = mal_seen && !stall;
        end else if (timeout) begin
          if (stall) begin
            next_state = HOLD;
            hold_load = 1'b1;
          end else begin
            fetch_done = 1'b1;
            fetch_fault = 1'b1;
            // ren low for one cycle to abandon the transfer
            next_state = IDLE;
          end
        end else if (!busy) begin
          if (stall) begin
            next_state = HOLD;
            hold_load = 1'b1;
          end else begin
            fetch_done = 1'b1;
          end
        end
      end
      HOLD: begin
        if (redirect) begin
          next_state = REQUEST;
        end else if (!stall) begin
          fetch_done = 1'b1;
          fetch_fault = held_fault;
          next_state = held_fault ? IDLE : REQUEST;
        end
      end
      DISCARD: begin
        // wait out the old transfer, then fetch the new pc
        if (timeout) begin
          next_state = IDLE;
        end else if (!busy) begin
          next_state = REQUEST;
        end
      end
      HALTED: next_state = REQUEST;
      default: next_state = IDLE;
    endcase
    // halt overrides everything
    if (halt) begin
      next_state = HALTED;
      fetch_done = 1'b0;
      fetch_fault = 1'b0;
      hold_load = 1'b0;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      mal_seen <= 1'b0;
      held_fault <= 1'b0;
    end else begin
      state <= next_state;
      mal_seen <= (state == REQUEST) && misaligned && !redirect && !halt && !fetch_done;
      if (hold_load) begin
        held_fault <= timeout;
      end
    end
  end

  // held word and stale transfer address
  always_ff @(posedge CLK) begin
    if (hold_load) begin
      held_word <= rdata;
    end
    if ((state == REQUEST) && (next_state == DISCARD)) begin
      discard_addr <= cur_pc;
    end
  end

endmodule

//--- rtl/ooo_fetch_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// out-of-order fetch stage top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module ooo_fetch_top import fetch_pkg::*; (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  halt,
  input  logic  stall,
  input  logic  if_id_flush,
  input  logic  npc_sel,
  input  word_t brj_addr,
  input  logic  insert_priv_pc,
  input  word_t priv_pc,
  input  logic  br_update,
  input  word_t br_update_pc,
  input  word_t br_update_target,
  input  logic  br_update_taken,
  input  logic  busy,
  input  word_t rdata,
  output word_t addr,
  output logic  ren,
  output logic  token,
  output word_t pc,
  output word_t pc4,
  output word_t instr,
  output logic  prediction,
  output logic  mal_insn,
  output logic  fault_insn
);

  word_t cur_pc;
  word_t cur_pc4;
  logic redirect;
  logic predict_taken;
  word_t target_addr;
  logic fetch_done;
  word_t fetch_word;
  logic fetch_fault;
  logic mal_addr;
  logic wait_active;
  logic timeout;

  // pc register and next-pc priority
  fetch_pc_select pc_sel_i (
    .CLK, .nRST, .halt, .stall, .fetch_done, .insert_priv_pc, .priv_pc,
    .npc_sel, .brj_addr, .predict_taken, .target_addr,
    .cur_pc, .cur_pc4, .redirect
  );

  // predictor, looked up on cur_pc
  branch_target_buffer btb_i (
    .CLK, .nRST, .cur_pc, .br_update, .br_update_pc, .br_update_target,
    .br_update_taken, .predict_taken, .target_addr
  );

  // bus side
  imem_fetch_fsm fsm_i (
    .CLK, .nRST, .halt, .stall, .redirect, .cur_pc, .busy, .rdata, .timeout,
    .addr, .ren, .fetch_done, .fetch_word, .fetch_fault, .mal_addr, .wait_active
  );

  fetch_wait_timer timer_i (
    .CLK, .nRST, .wait_active, .timeout
  );

  // if/id register toward decode
  fetch_decode_latch latch_i (
    .CLK, .nRST, .halt, .stall, .if_id_flush, .redirect, .fetch_done,
    .cur_pc, .cur_pc4, .fetch_word, .predict_taken, .mal_addr, .fetch_fault,
    .token, .pc, .pc4, .instr, .prediction, .mal_insn, .fault_insn
  );

endmodule
